// ==== list.f ====
+incdir+tests
source/frame_gen_pkg.sv
source/frame_fsm.sv
source/beat_counter.sv
source/crc32_beat.sv
source/frame_assembler.sv
source/frame_gen_top.sv
tests/tb_frame_gen.sv

// ==== Makefile ====
# Verilator flow for the frame generator

VERILATOR ?= verilator
FILELIST  ?= list.f
TOP       ?= tb_frame_gen
DUT_TOP   ?= frame_gen_top
BUILD_DIR ?= obj_dir
PASS_MSG  ?= TB PASSED
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# pass only when the pass line shows up in the output
sim: build
	@out="$$($(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/frame_model.svh ====
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// expects PAYLOAD_LEN and PAYLOAD_PAT from the including module

// payload bytes actually used
function automatic int model_eff_len(input len_t req_len);
    if (int'(req_len) > PAYLOAD_LEN) begin
        return PAYLOAD_LEN;
    end
    return int'(req_len);
endfunction

// header, payload and padding, rounded up to whole beats
function automatic int model_body_bytes(input len_t req_len);
    int pay;
    int total;
    pay = model_eff_len(req_len);
    if (pay < MIN_PAYLOAD_BYTES) begin
        pay = MIN_PAYLOAD_BYTES;    // short frames padded with zeros
    end
    total = HEADER_BYTES + pay;
    if ((total % BEAT_BYTES) != 0) begin
        total = total + BEAT_BYTES - (total % BEAT_BYTES);
    end
    return total;
endfunction

function automatic int model_body_beats(input len_t req_len);
    return model_body_bytes(req_len) / BEAT_BYTES;
endfunction

// body byte n in wire order
function automatic byte_t model_body_byte(
    input frame_header_t            hdr,
    input byte_t [PAYLOAD_LEN-1:0]  pay,
    input len_t                     req_len,
    input mode_t                    mode,
    input int                       n
);
    int p;
    p = n - HEADER_BYTES;
    if (n < 6) begin
        return hdr.dest[47 - 8 * n -: 8];
    end else if (n < 12) begin
        return hdr.src[47 - 8 * (n - 6) -: 8];
    end else if (n < HEADER_BYTES) begin
        return hdr.eth_type[15 - 8 * (n - 12) -: 8];
    end else if (p < model_eff_len(req_len)) begin
        return (mode == MODE_FIXED_PAYLOAD) ? PAYLOAD_PAT : pay[p];
    end
    return 8'h00;
endfunction

// one byte into the crc, msb first
function automatic crc_t model_crc_byte(input crc_t crc, input byte_t data);
    crc_t c;
    c = crc ^ {data, 24'h000000};
    for (int k = 0; k < 8; k++) begin
        if (c[31]) begin
            c = {c[30:0], 1'b0} ^ CRC_POLY;
        end else begin
            c = {c[30:0], 1'b0};
        end
    end
    return c;
endfunction

`endif

// ==== tests/tb_frame_gen.sv ====
`timescale 1ns/1ps

module tb_frame_gen;

    import frame_gen_pkg::*;

    localparam int    PAYLOAD_LEN  = 16;
    localparam byte_t PAYLOAD_PAT  = 8'h55;
    localparam int    NUM_FRAMES   = 40;
    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 16;
    localparam int    MAX_GAP      = 6;
    // longest frame plus gap stays well under 20 cycles
    localparam int    TIMEOUT_NS   = (NUM_FRAMES * 20 + RESET_CYCLES + 50) * CLK_PERIOD;

    `include "frame_model.svh"

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    frame_header_t              header;
    len_t                       payload_length;
    byte_t [PAYLOAD_LEN-1:0]    payload;
    mode_t                      mode;
    logic                       valid;
    beat_t                      frame_out;
    logic                       done;

    integer seed;
    beat_t  exp_beats[$];
    crc_t   exp_fcs;

    frame_gen_top #(
        .PAYLOAD_LENGTH  (PAYLOAD_LEN),
        .PAYLOAD_PATTERN (PAYLOAD_PAT)
    ) u_frame_gen_top (
        .clk              (clk),
        .i_rst_n          (rst_n),
        .i_start          (start),
        .i_header         (header),
        .i_payload_length (payload_length),
        .i_payload        (payload),
        .i_mode           (mode),
        .o_valid          (valid),
        .o_frame_out      (frame_out),
        .o_done           (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic expect_idle();
        check_value("o_valid", 64'(valid), 64'(1'b0));
        check_value("o_done", 64'(done), 64'(1'b0));
        check_value("o_frame_out", frame_out, 64'h0);
    endtask

    task automatic randomize_inputs();
        logic [127:0] raw;
        int           pick;
        raw    = {$random(seed), $random(seed), $random(seed), $random(seed)};
        header = raw[111:0];
        for (int i = 0; i < PAYLOAD_LEN; i++) begin
            payload[i] = byte_t'($random(seed));
        end
        payload_length = len_t'($unsigned($random(seed)) % 21);    // up to 20, above the preload
        pick = $unsigned($random(seed)) % 4;
        case (pick)
            0, 1:    mode = MODE_FIXED_PAYLOAD;
            2:       mode = 8'h00;
            default: mode = mode_t'($random(seed));    // any other code
        endcase
    endtask

    // fresh inputs mid frame, sometimes with a stray start
    task automatic disturb_inputs(input bit force_start);
        randomize_inputs();
        start = force_start || (($random(seed) & 3) == 0);
    endtask

    // expected body beats and fcs for the inputs now on the pins
    task automatic build_expected();
        int    nbytes;
        beat_t beat;
        crc_t  crc;
        byte_t b;
        exp_beats.delete();
        nbytes = model_body_bytes(payload_length);
        crc    = CRC_INIT;
        beat   = '0;
        for (int n = 0; n < nbytes; n++) begin
            b    = model_body_byte(header, payload, payload_length, mode, n);
            crc  = model_crc_byte(crc, b);
            beat = {beat[55:0], b};    // first byte ends up on top
            if ((n % BEAT_BYTES) == BEAT_BYTES - 1) begin
                exp_beats.push_back(beat);
            end
        end
        exp_fcs = ~crc;
    endtask

    task automatic run_frame(input int index);
        int beats;
        bit late_start;
        randomize_inputs();
        build_expected();
        beats      = model_body_beats(payload_length);
        late_start = (index % 2) == 1;    // lands on the edge that registers done
        start      = 1'b1;
        @(negedge clk);
        expect_idle();    // output stage one register behind
        disturb_inputs(1'b0);
        for (int n = 0; n <= beats; n++) begin
            @(negedge clk);
            check_value("o_valid", 64'(valid), 64'(1'b1));
            check_value("o_done", 64'(done), 64'(1'b0));
            if (n == 0) begin
                check_value("o_frame_out preamble", frame_out, PREAMBLE_SFD);
            end else begin
                check_value($sformatf("o_frame_out beat %0d", n - 1), frame_out, exp_beats[n-1]);
            end
            disturb_inputs(late_start && (n == beats));
        end
        @(negedge clk);
        check_value("o_valid", 64'(valid), 64'(1'b0));
        check_value("o_done", 64'(done), 64'(1'b1));
        check_value("o_frame_out fcs", frame_out, {exp_fcs, 32'h0});
        start = 1'b0;
    endtask

    initial begin
        int gap;
        seed           = 32'h3f6ef4ef;
        clk            = 1'b0;
        rst_n          = 1'b0;
        start          = 1'b0;
        header         = '0;
        payload_length = '0;
        payload        = '0;
        mode           = '0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            expect_idle();
        end
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            expect_idle();    // nothing before the first start
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
            gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            repeat (gap) begin
                @(negedge clk);
                expect_idle();
            end
        end
        $display("TB PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out at %0t before all frames were checked", $time);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== source/frame_gen_top.sv ====
`timescale 1ns/1ps

module frame_gen_top #(
    parameter int                   PAYLOAD_LENGTH  = 16,
    parameter frame_gen_pkg::byte_t PAYLOAD_PATTERN = 8'h55
) (
    input  logic                                      clk,
    input  logic                                      i_rst_n,
    input  logic                                      i_start,
    input  frame_gen_pkg::frame_header_t              i_header,
    input  frame_gen_pkg::len_t                       i_payload_length,
    input  frame_gen_pkg::byte_t [PAYLOAD_LENGTH-1:0] i_payload,
    input  frame_gen_pkg::mode_t                      i_mode,
    output logic                                      o_valid,
    output frame_gen_pkg::beat_t                      o_frame_out,
    output logic                                      o_done
);

    import frame_gen_pkg::*;

    // fsm decodes
    logic  load;
    logic  preamble;
    logic  body;
    logic  fcs;

    logic  body_last;
    beat_t body_beat;    // feeds the crc
    crc_t  fcs_value;

    frame_fsm u_fsm (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_body_last (body_last),
        .o_load      (load),
        .o_preamble  (preamble),
        .o_body      (body),
        .o_fcs       (fcs)
    );

    beat_counter #(
        .PAYLOAD_LENGTH (PAYLOAD_LENGTH)
    ) u_counter (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_load           (load),
        .i_body           (body),
        .i_payload_length (i_payload_length),
        .o_body_last      (body_last)
    );

    crc32_beat u_crc (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_init      (load),
        .i_update    (body),
        .i_data      (body_beat),
        .o_fcs_value (fcs_value)
    );

    frame_assembler #(
        .PAYLOAD_LENGTH  (PAYLOAD_LENGTH),
        .PAYLOAD_PATTERN (PAYLOAD_PATTERN)
    ) u_assembler (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_load           (load),
        .i_preamble       (preamble),
        .i_body           (body),
        .i_fcs            (fcs),
        .i_header         (i_header),
        .i_payload        (i_payload),
        .i_payload_length (i_payload_length),
        .i_mode           (i_mode),
        .i_fcs_value      (fcs_value),
        .o_body_beat      (body_beat),
        .o_valid          (o_valid),
        .o_done           (o_done),
        .o_frame_out      (o_frame_out)
    );

endmodule

// ==== source/frame_assembler.sv ====
`timescale 1ns/1ps

module frame_assembler #(
    parameter int                  PAYLOAD_LENGTH  = 16,
    parameter frame_gen_pkg::byte_t PAYLOAD_PATTERN = 8'h55
) (
    input  logic                                       clk,
    input  logic                                       i_rst_n,
    input  logic                                       i_load,
    input  logic                                       i_preamble,
    input  logic                                       i_body,
    input  logic                                       i_fcs,
    input  frame_gen_pkg::frame_header_t               i_header,
    input  frame_gen_pkg::byte_t [PAYLOAD_LENGTH-1:0]  i_payload,
    input  frame_gen_pkg::len_t                        i_payload_length,
    input  frame_gen_pkg::mode_t                       i_mode,
    input  frame_gen_pkg::crc_t                        i_fcs_value,
    output frame_gen_pkg::beat_t                       o_body_beat,
    output logic                                       o_valid,
    output logic                                       o_done,
    output frame_gen_pkg::beat_t                       o_frame_out
);

    import frame_gen_pkg::*;

    localparam int BYTE_W  = $bits(byte_t);
    localparam int BEAT_W  = $bits(beat_t);
    localparam int HDR_W   = $bits(frame_header_t);

    // longest body: header plus the larger of preload and minimum payload
    localparam int MAX_PAYLOAD = (PAYLOAD_LENGTH > MIN_PAYLOAD_BYTES) ?
                                 PAYLOAD_LENGTH : MIN_PAYLOAD_BYTES;
    localparam int MAX_BEATS   = (HEADER_BYTES + MAX_PAYLOAD + BEAT_BYTES - 1) / BEAT_BYTES;
    localparam int SHIFT_W     = MAX_BEATS * BEAT_W;

    logic [SHIFT_W-1:0] load_image;
    logic [SHIFT_W-1:0] shift_q;
    len_t               eff_len;
    logic               fixed_mode;

    assign eff_len    = clamp_len(i_payload_length, len_t'(PAYLOAD_LENGTH));
    assign fixed_mode = (i_mode == MODE_FIXED_PAYLOAD);

    // header at the top, payload right behind it, zeros to the end
    always_comb begin
        byte_t pay_byte;
        load_image = '0;
        load_image[SHIFT_W-1 -: HDR_W] = i_header;
        for (int i = 0; i < PAYLOAD_LENGTH; i++) begin
            pay_byte = fixed_mode ? PAYLOAD_PATTERN : i_payload[i];
            if (len_t'(i) >= eff_len) begin
                pay_byte = '0;    // past the requested length
            end
            load_image[SHIFT_W - 1 - BYTE_W * (HEADER_BYTES + i) -: BYTE_W] = pay_byte;
        end
    end

    // body shift register, one beat out per body cycle
    always_ff @(posedge clk) begin
        if (i_load) begin
            shift_q <= load_image;
        end else if (i_body) begin
            shift_q <= {shift_q[SHIFT_W-BEAT_W-1:0], beat_t'(0)};
        end
    end

    assign o_body_beat = shift_q[SHIFT_W-1 -: BEAT_W];

    // output stage, one register behind the fsm decodes
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid     <= 1'b0;
            o_done      <= 1'b0;
            o_frame_out <= '0;
        end else begin
            o_valid <= i_preamble || i_body;
            o_done  <= i_fcs;
            if (i_preamble) begin
                o_frame_out <= PREAMBLE_SFD;
            end else if (i_body) begin
                o_frame_out <= o_body_beat;
            end else if (i_fcs) begin
                o_frame_out <= {i_fcs_value, crc_t'(0)};    // fcs in upper half
            end else begin
                o_frame_out <= '0;
            end
        end
    end

endmodule

// ==== source/crc32_beat.sv ====
`timescale 1ns/1ps

module crc32_beat (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_init,
    input  logic                 i_update,
    input  frame_gen_pkg::beat_t i_data,
    output frame_gen_pkg::crc_t  o_fcs_value
);

    import frame_gen_pkg::*;

    crc_t crc_q;
    crc_t crc_next;

    // fold all 64 bits, msb first, one bit per step
    always_comb begin
        logic feedback;
        crc_next = crc_q;
        for (int i = 0; i < $bits(beat_t); i++) begin
            feedback = crc_next[31] ^ i_data[$bits(beat_t) - 1 - i];
            crc_next = {crc_next[30:0], 1'b0};
            if (feedback) begin
                crc_next = crc_next ^ CRC_POLY;
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            crc_q <= CRC_INIT;
        end else if (i_init) begin
            crc_q <= CRC_INIT;    // fresh frame
        end else if (i_update) begin
            crc_q <= crc_next;
        end
    end

    assign o_fcs_value = ~crc_q;    // fcs is sent complemented

endmodule

// ==== source/beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter #(
    parameter int PAYLOAD_LENGTH = 16
) (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_load,
    input  logic                i_body,
    input  frame_gen_pkg::len_t i_payload_length,
    output logic                o_body_last
);

    import frame_gen_pkg::*;

    len_t eff_len;
    len_t padded_len;
    len_t body_bytes;
    len_t body_beats;
    len_t last_q;     // body beats minus one
    len_t count_q;

    // body length in whole beats, header included
    always_comb begin
        eff_len    = clamp_len(i_payload_length, len_t'(PAYLOAD_LENGTH));
        padded_len = (eff_len < len_t'(MIN_PAYLOAD_BYTES)) ? len_t'(MIN_PAYLOAD_BYTES) : eff_len;
        body_bytes = padded_len + len_t'(HEADER_BYTES);
        body_beats = (body_bytes + len_t'(BEAT_BYTES - 1)) / len_t'(BEAT_BYTES);
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            last_q  <= '0;
            count_q <= '0;
        end else if (i_load) begin
            last_q  <= body_beats - 16'd1;
            count_q <= '0;
        end else if (i_body) begin
            count_q <= count_q + 16'd1;
        end
    end

    // high during the final body beat
    assign o_body_last = i_body && (count_q == last_q);

endmodule

// ==== source/frame_fsm.sv ====
`timescale 1ns/1ps

module frame_fsm (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_body_last,
    output logic o_load,
    output logic o_preamble,
    output logic o_body,
    output logic o_fcs
);

    import frame_gen_pkg::*;

    fsm_state_t state_q;
    fsm_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_start) begin
                    state_d = ST_PREAMBLE;
                end
            end
            ST_PREAMBLE: begin
                state_d = ST_BODY;    // always exactly one preamble beat
            end
            ST_BODY: begin
                if (i_body_last) begin
                    state_d = ST_FCS;
                end
            end
            ST_FCS: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // start only counts while idle
    assign o_load     = (state_q == ST_IDLE) && i_start;
    assign o_preamble = (state_q == ST_PREAMBLE);
    assign o_body     = (state_q == ST_BODY);
    assign o_fcs      = (state_q == ST_FCS);

endmodule

// ==== source/frame_gen_pkg.sv ====
package frame_gen_pkg;

    // basic widths
    typedef logic [7:0]  byte_t;
    typedef logic [63:0] beat_t;     // first wire byte in bits 63:56
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;
    typedef logic [15:0] len_t;      // byte or beat count
    typedef logic [31:0] crc_t;
    typedef logic [7:0]  mode_t;

    // dest is sent first so it sits in the top bits
    typedef struct packed {
        mac_addr_t dest;
        mac_addr_t src;
        eth_type_t eth_type;
    } frame_header_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_BODY,
        ST_FCS
    } fsm_state_t;

    // 7 bytes of preamble then the SFD
    localparam beat_t PREAMBLE_SFD = 64'h55555555555555D5;

    localparam int HEADER_BYTES      = 14;
    localparam int MIN_PAYLOAD_BYTES = 46;
    localparam int BEAT_BYTES        = 8;

    localparam crc_t CRC_POLY = 32'h04C11DB7;
    localparam crc_t CRC_INIT = 32'hFFFFFFFF;

    // every payload byte replaced by the pattern
    localparam mode_t MODE_FIXED_PAYLOAD = 8'd1;

    // payload length limited to what is preloaded
    function automatic len_t clamp_len(input len_t len, input len_t max_len);
        return (len > max_len) ? max_len : len;
    endfunction

endpackage
